// ==== src.f ====
hdl/palimpsest_pkg.sv
hdl/host_bus_decoder.sv
hdl/asic_word_deserializer.sv
hdl/register_bank.sv
hdl/command_pulser.sv
hdl/sample_fifo.sv
hdl/readback_mux.sv
hdl/palimpsest_top.sv
tb/tb_palimpsest.sv

// ==== tb/tb_palimpsest.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_palimpsest;

	localparam int timeout_cycles_c = 16; // per wait loop
	localparam int fifo_depth_c = 64;

	logic sysclk;
	logic reset;
	logic host_strobe;
	logic host_read;
	logic host_register_select;
	logic [15:0] host_data_in;
	logic [15:0] host_read_data;
	logic host_ack;
	logic asic_data;
	logic ls_i2c;
	logic [48:0] asic_settings;
	logic [3:0] command_pulses; // dreset, legacy_serial, i2c, trigger

	logic [31:0] lfsr;
	// ------------------------------
	// model
	logic [31:0] model_bank [8][16]; // only banks 0 and 3 used
	logic [3:0] model_flags;         // sticky, by command number
	logic [7:0] model_triggers;
	int model_pulses [4];
	int seen_pulses [4];             // counted off the dut outputs
	logic [15:0] model_fifo [$];
	int model_received;
	int model_read;
	int model_errors;

	palimpsest_top #(.ADDRESS_AUTOINCREMENT(1), .LOG2_OF_DEPTH(6), .ERROR_COUNT_WIDTH(24)) dut (
		.sysclk, .reset, .host_strobe, .host_read, .host_register_select, .host_data_in,
		.host_read_data, .host_ack, .asic_data, .ls_i2c, .asic_settings, .command_pulses);

	initial begin
		sysclk = 1'b0;
		forever #20 sysclk = ~sysclk;
	end

	// pulses are one cycle wide, seen once at the falling edge
	always @(negedge sysclk) begin
		if (!reset) begin
			for (int n = 0; n < 4; n++) begin
				if (command_pulses[3 - n]) begin
					seen_pulses[n]++;
				end
			end
		end
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [15:0] make_address(input logic [2:0] bank, input logic [3:0] word);
		logic [8:0] filler; // offset bits above the word select
		filler = random_bits(9);
		return {bank, filler, word};
	endfunction

	// field decode of bank 3
	function automatic logic [48:0] expected_settings();
		return {model_bank[3][1][7:0], model_bank[3][2][0], model_bank[3][3][7:0],
			model_bank[3][4][7:0], model_bank[3][5][7:0], model_bank[3][15][15:0]};
	endfunction

	// ------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// one strobe, wait for ack, then one idle cycle
	task automatic drive_transaction(input logic is_read, input logic is_data,
			input logic [15:0] data_in, output logic [15:0] data_out);
		int waited;
		host_strobe = 1'b1;
		host_read = is_read;
		host_register_select = is_data;
		host_data_in = data_in;
		@(negedge sysclk);
		host_strobe = 1'b0;
		waited = 0;
		while (!host_ack) begin
			if (waited == timeout_cycles_c) begin
				abort_run("no host_ack after a bus strobe");
			end
			@(negedge sysclk);
			waited++;
		end
		data_out = host_read_data;
		@(negedge sysclk);
	endtask

	task automatic set_address(input logic [15:0] addr);
		logic [15:0] unused;
		drive_transaction(1'b0, 1'b0, addr, unused);
	endtask

	task automatic fetch_address(output logic [15:0] addr);
		drive_transaction(1'b1, 1'b0, 16'h0, addr);
	endtask

	task automatic put_data(input logic [31:0] data);
		logic [15:0] unused;
		drive_transaction(1'b0, 1'b1, data[31:16], unused); // upper half first
		drive_transaction(1'b0, 1'b1, data[15:0], unused);
	endtask

	task automatic get_data(output logic [31:0] data);
		logic [15:0] upper;
		logic [15:0] lower;
		drive_transaction(1'b1, 1'b1, 16'h0, upper);
		drive_transaction(1'b1, 1'b1, 16'h0, lower);
		data = {upper, lower};
	endtask

	task automatic store_word(input logic [2:0] bank, input logic [3:0] word,
			input logic [31:0] data);
		set_address(make_address(bank, word));
		put_data(data);
	endtask

	task automatic load_word(input logic [2:0] bank, input logic [3:0] word,
			output logic [31:0] data);
		set_address(make_address(bank, word));
		get_data(data);
	endtask

	task automatic read_status(input logic [3:0] word, output logic [31:0] data);
		load_word(3'd1, word, data);
	endtask

	// start bit, 16 bits msb first, idle gap; model follows the fifo rules
	task automatic send_sample(input logic [15:0] sample, input int gap);
		asic_data = 1'b0;
		@(negedge sysclk);
		for (int i = 15; i >= 0; i--) begin
			asic_data = sample[i];
			@(negedge sysclk);
		end
		asic_data = 1'b1;
		repeat (gap) @(negedge sysclk);
		model_received++;
		if (model_fifo.size() < fifo_depth_c) begin
			model_fifo.push_back(sample);
		end else begin
			model_errors++; // dropped when full
		end
	endtask

	task automatic wait_for_samples();
		int polls;
		logic [31:0] count;
		polls = 0;
		read_status(4'd5, count);
		while (count != model_received) begin
			if (polls == timeout_cycles_c) begin
				abort_run("deserializer never counted all the sent frames");
			end
			read_status(4'd5, count);
			polls++;
		end
	endtask

	// ------------------------------
	initial begin
		logic [31:0] value;
		logic [31:0] data;
		logic [15:0] addr;
		logic [15:0] sample;
		logic [3:0] word;
		logic [2:0] bank;
		host_strobe = 1'b0;
		host_read = 1'b0;
		host_register_select = 1'b0;
		host_data_in = '0;
		asic_data = 1'b1; // serial line idles high
		reset = 1'b1;
		lfsr = 32'hb6d1c535;
		model_flags = '0;
		model_triggers = '0;
		model_received = 0;
		model_read = 0;
		model_errors = 0;
		for (int b = 0; b < 8; b++) begin
			for (int w = 0; w < 16; w++) begin
				model_bank[b][w] = '0;
			end
		end
		for (int n = 0; n < 4; n++) begin
			model_pulses[n] = 0;
			seen_pulses[n] = 0;
		end
		repeat (3) @(posedge sysclk);
		@(negedge sysclk);
		reset = 1'b0;
		read_status(4'd2, value);
		check("empty after reset", 1, value);

		// banks 0 and 3, every word once then random
		for (int i = 0; i < 32; i++) begin
			bank = i[0] ? 3'd3 : 3'd0;
			word = i[4:1];
			data = random_bits(32);
			store_word(bank, word, data);
			model_bank[bank][word] = data;
		end
		for (int i = 0; i < 24; i++) begin
			bank = random_bits(1) ? 3'd3 : 3'd0;
			word = random_bits(4);
			data = random_bits(32);
			store_word(bank, word, data);
			model_bank[bank][word] = data;
			load_word(bank, word, value);
			check("bank readback", model_bank[bank][word], value);
		end
		check("ls_i2c", model_bank[0][0][0], ls_i2c);
		check("asic_settings", expected_settings(), asic_settings);

		// auto-increment, one address then consecutive words
		bank = random_bits(1) ? 3'd3 : 3'd0;
		word = random_bits(4);
		addr = make_address(bank, word);
		set_address(addr);
		for (int i = 0; i < 5; i++) begin
			data = random_bits(32);
			put_data(data);
			model_bank[bank][word + i[3:0]] = data; // wraps inside the bank
		end
		set_address(addr);
		for (int i = 0; i < 5; i++) begin
			get_data(value);
			check("auto-increment readback", model_bank[bank][word + i[3:0]], value);
		end
		check("asic_settings after increment", expected_settings(), asic_settings);

		// command bank, words 4 to 7 do nothing
		for (int i = 0; i < 12; i++) begin
			word = random_bits(3);
			store_word(3'd2, word, random_bits(32));
			if (word < 4) begin
				model_flags[word] = 1'b1;
				model_pulses[word]++;
				if (word == 3) begin
					model_triggers++;
				end
			end
		end
		read_status(4'd0, value);
		check("sticky flags", model_flags, value);
		read_status(4'd1, value);
		check("trigger count", model_triggers, value);
		for (int n = 0; n < 4; n++) begin
			check("command pulses", model_pulses[n], seen_pulses[n]);
		end

		// ------------------------------
		// serial samples with random gaps
		for (int i = 0; i < 20; i++) begin
			send_sample(random_bits(16), random_bits(2));
		end
		wait_for_samples();
		set_address(make_address(3'd5, 4'd0));
		while (model_fifo.size() > 0) begin
			sample = model_fifo.pop_front();
			get_data(value);
			check("fifo sample", {16'h0, sample}, value);
			model_read++;
		end
		read_status(4'd2, value);
		check("empty after drain", 1, value);
		read_status(4'd5, value);
		check("words received", model_received, value);
		read_status(4'd6, value);
		check("words read", model_read, value);

		// overflow then underflow
		for (int i = 0; i < fifo_depth_c + 6; i++) begin
			send_sample(random_bits(16), 0);
		end
		wait_for_samples();
		set_address(make_address(3'd5, 4'd0));
		for (int i = 0; i < fifo_depth_c; i++) begin
			sample = model_fifo.pop_front();
			get_data(value);
			check("fifo sample after overflow", {16'h0, sample}, value);
			model_read++;
		end
		for (int i = 0; i < 3; i++) begin
			get_data(value);
			check("pop on empty", 0, value);
			model_errors++;
		end
		read_status(4'd4, value);
		check("fifo error count", model_errors, value);
		read_status(4'd2, value);
		check("empty after underflow", 1, value);
		read_status(4'd6, value);
		check("words read after underflow", model_read, value);

		// unused banks and address readback
		for (int i = 0; i < 9; i++) begin
			case (random_bits(2) % 3)
				0: bank = 3'd4;
				1: bank = 3'd6;
				default: bank = 3'd7;
			endcase
			word = random_bits(4);
			store_word(bank, word, random_bits(32));
			load_word(bank, word, value);
			check("unused bank", 0, value);
		end
		for (int i = 0; i < 4; i++) begin
			addr = random_bits(16);
			set_address(addr);
			fetch_address(value[15:0]);
			check("address readback", addr, value[15:0]);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/palimpsest_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module palimpsest_top
	import palimpsest_pkg::*;
#(
	parameter bit ADDRESS_AUTOINCREMENT = 1,
	parameter int LOG2_OF_DEPTH = 6,
	parameter int ERROR_COUNT_WIDTH = 24
) (
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic host_strobe,
	input  wire logic host_read,
	input  wire logic host_register_select,
	input  wire logic [bus_width_c-1:0] host_data_in,
	output logic [bus_width_c-1:0] host_read_data,
	output logic host_ack,
	input  wire logic asic_data,
	output logic ls_i2c,                 // 0=i2c 1=ls
	output asic_settings_t asic_settings,
	output command_pulses_t command_pulses
);
	host_address_t address;
	data_word_t write_data, read_word, general_word, asic_word;
	bank_strobes_t write_strobe, read_strobe;
	data_word_t general_words [1 << word_sel_width_c];
	data_word_t asic_words [1 << word_sel_width_c];
	logic [word_sel_width_c-1:0] word_sel;
	logic [3:0] occurred;
	logic [7:0] trigger_count;
	logic sample_strobe, fifo_empty;
	sample_t sample_word, fifo_head;
	logic [31:0] words_received, words_read;
	logic [ERROR_COUNT_WIDTH-1:0] fifo_error_count;

	assign word_sel = address.offset[word_sel_width_c-1:0];

	// ------------------------------
	host_bus_decoder #(.ADDRESS_AUTOINCREMENT(ADDRESS_AUTOINCREMENT)) decoder (.sysclk, .reset,
		.host_strobe, .host_read, .host_register_select, .host_data_in, .read_word,
		.host_read_data, .host_ack, .address, .write_data, .write_strobe, .read_strobe);

	register_bank general_bank (.sysclk, .reset, .word_sel, .write_data,
		.write_strobe(write_strobe[bank_general_c]), .read_word(general_word),
		.all_words(general_words));
	register_bank asic_bank (.sysclk, .reset, .word_sel, .write_data,
		.write_strobe(write_strobe[bank_asic_c]), .read_word(asic_word), .all_words(asic_words));

	command_pulser pulser (.sysclk, .reset, .word_sel, .write_strobe(write_strobe[bank_command_c]),
		.command_pulses, .occurred, .trigger_count);

	// ------------------------------
	// asic sample path
	asic_word_deserializer deserializer (.sysclk, .reset, .asic_data, .sample_strobe,
		.sample_word, .words_received);
	sample_fifo #(.LOG2_OF_DEPTH(LOG2_OF_DEPTH), .ERROR_COUNT_WIDTH(ERROR_COUNT_WIDTH)) fifo (
		.sysclk, .reset, .push(sample_strobe), .push_data(sample_word),
		.pop(read_strobe[bank_fifo_c]), .head(fifo_head), .empty(fifo_empty),
		.error_count(fifo_error_count), .words_read);

	readback_mux #(.ERROR_COUNT_WIDTH(ERROR_COUNT_WIDTH)) readback (.bank_sel(address.bank),
		.word_sel, .general_word, .asic_word, .occurred, .trigger_count, .fifo_empty,
		.fifo_error_count, .words_received, .words_read, .fifo_head, .read_word);

	// ------------------------------
	assign ls_i2c = general_words[0][0];
	assign asic_settings = '{
		i2c_up_addr:           asic_words[1][7:3],
		lvdsb_pwr:             asic_words[1][2],
		lvdsa_pwr:             asic_words[1][1],
		src_sel:               asic_words[1][0],
		tm_reg_reset:          asic_words[2][0],
		samples_after_trigger: asic_words[3][7:0],
		lookback_windows:      asic_words[4][7:0],
		number_of_samples:     asic_words[5][7:0],
		i2c_register_enables:  asic_words[15][15:0]
	};

endmodule

`default_nettype wire

// ==== hdl/readback_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

module readback_mux
	import palimpsest_pkg::*;
#(
	parameter int ERROR_COUNT_WIDTH = 24
) (
	input  wire logic [bank_sel_width_c-1:0] bank_sel,
	input  wire logic [word_sel_width_c-1:0] word_sel,
	input  wire data_word_t general_word,   // bank 0
	input  wire data_word_t asic_word,      // bank 3
	input  wire logic [3:0] occurred,
	input  wire logic [7:0] trigger_count,
	input  wire logic fifo_empty,
	input  wire logic [ERROR_COUNT_WIDTH-1:0] fifo_error_count,
	input  wire logic [31:0] words_received,
	input  wire logic [31:0] words_read,
	input  wire sample_t fifo_head,
	output data_word_t read_word
);
	data_word_t status_word;

	// ------------------------------
	// status bank 1
	always_comb begin
		status_word = '0;
		case (word_sel)
			4'd0: status_word[3:0] = occurred;      // sticky command flags
			4'd1: status_word[7:0] = trigger_count;
			4'd2: status_word[0] = fifo_empty;
			4'd4: status_word[ERROR_COUNT_WIDTH-1:0] = fifo_error_count;
			4'd5: status_word = words_received;     // into fifo
			4'd6: status_word = words_read;         // out of fifo
			default: status_word = '0;
		endcase
	end

	// ------------------------------
	// bank select
	always_comb begin
		case (bank_sel)
			bank_general_c: read_word = general_word;
			bank_status_c:  read_word = status_word;
			bank_asic_c:    read_word = asic_word;
			bank_fifo_c:    read_word = data_word_t'(fifo_head); // zero extended
			default:        read_word = '0; // command bank, 4, 6, 7
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module sample_fifo
	import palimpsest_pkg::*;
#(
	parameter int LOG2_OF_DEPTH = 6,
	parameter int ERROR_COUNT_WIDTH = 24
) (
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic push,
	input  wire sample_t push_data,
	input  wire logic pop,
	output sample_t head,         // first word falls through
	output logic empty,
	output logic [ERROR_COUNT_WIDTH-1:0] error_count,
	output logic [31:0] words_read
);
	localparam int depth_c = 1 << LOG2_OF_DEPTH;

	sample_t mem [depth_c];
	logic [LOG2_OF_DEPTH-1:0] write_pointer;
	logic [LOG2_OF_DEPTH-1:0] read_pointer;
	logic [LOG2_OF_DEPTH:0] fill; // one extra bit to hold depth_c
	logic full;
	logic push_ok;
	logic pop_ok;
	logic rejected;

	assign empty = fill == '0;
	assign full = fill == (LOG2_OF_DEPTH + 1)'(depth_c);
	assign push_ok = push && !full;   // push while full drops the sample
	assign pop_ok = pop && !empty;    // pop while empty ignored
	assign rejected = (push && full) || (pop && empty);
	assign head = empty ? '0 : mem[read_pointer];

	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			fill <= '0;
			error_count <= '0;
			words_read <= '0;
		end else begin
			if (push_ok) begin
				write_pointer <= write_pointer + 1'b1; // wraps at depth
			end
			if (pop_ok) begin
				read_pointer <= read_pointer + 1'b1;
				words_read <= words_read + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill; // both or neither
			endcase
			if (rejected && (error_count != '1)) begin
				error_count <= error_count + 1'b1; // saturates
			end
		end
	end

	// storage
	always_ff @(posedge sysclk) begin
		if (push_ok) begin
			mem[write_pointer] <= push_data;
		end
	end

	assert property (@(posedge sysclk) disable iff (reset) fill <= depth_c);

endmodule

`default_nettype wire

// ==== hdl/command_pulser.sv ====
`default_nettype none
`timescale 1ns/1ps

module command_pulser
	import palimpsest_pkg::*;
(
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic [word_sel_width_c-1:0] word_sel,
	input  wire logic write_strobe, // bank 2 write, data ignored
	output command_pulses_t command_pulses,
	output logic [3:0] occurred,    // sticky, indexed by command number
	output logic [7:0] trigger_count
);
	localparam int commands_c = 4;

	logic [commands_c-1:0] fire; // one-cycle pulses, indexed by command number
	logic valid_command;

	assign valid_command = write_strobe && (word_sel < commands_c); // words 4+ do nothing

	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			fire <= '0;
			occurred <= '0;
			trigger_count <= '0;
		end else begin
			fire <= '0;
			if (valid_command) begin
				fire[word_sel[1:0]] <= 1'b1;
				occurred[word_sel[1:0]] <= 1'b1;
				if (word_sel == cmd_trigger_c) begin
					trigger_count <= trigger_count + 1'b1; // wraps
				end
			end
		end
	end

	assign command_pulses = '{
		dreset:        fire[cmd_dreset_c],
		legacy_serial: fire[cmd_legacy_serial_c],
		i2c:           fire[cmd_i2c_c],
		trigger:       fire[cmd_trigger_c]
	};

	// ------------------------------
	// trigger counter moves only with a trigger pulse
	assert property (@(posedge sysclk) disable iff (reset)
		trigger_count == 8'($past(trigger_count) + command_pulses.trigger));

endmodule

`default_nettype wire

// ==== hdl/register_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module register_bank
	import palimpsest_pkg::*;
(
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic [word_sel_width_c-1:0] word_sel,
	input  wire data_word_t write_data,
	input  wire logic write_strobe,   // this bank's strobe only
	output data_word_t read_word,
	output data_word_t all_words [1 << word_sel_width_c]
);
	localparam int words_c = 1 << word_sel_width_c;

	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < words_c; i++) begin
				all_words[i] <= '0;
			end
		end else if (write_strobe) begin
			all_words[word_sel] <= write_data;
		end
	end

	// readback of whatever word is addressed
	assign read_word = all_words[word_sel];

endmodule

`default_nettype wire

// ==== hdl/asic_word_deserializer.sv ====
`default_nettype none
`timescale 1ns/1ps

module asic_word_deserializer
	import palimpsest_pkg::*;
(
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic asic_data,      // idle high, start bit low, 16 bits msb first
	output logic sample_strobe,
	output sample_t sample_word,
	output logic [31:0] words_received
);
	localparam int sample_bits_c = $bits(sample_t);
	localparam int count_width_c = $clog2(sample_bits_c);

	logic receiving;                       // start bit seen, data bits coming
	logic [count_width_c-1:0] bit_count;
	logic [sample_bits_c-2:0] shift;       // all but the last bit
	logic last_bit;

	assign last_bit = bit_count == count_width_c'(sample_bits_c - 1);

	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			receiving <= 1'b0;
			bit_count <= '0;
			sample_strobe <= 1'b0;
			words_received <= '0;
		end else begin
			sample_strobe <= 1'b0;
			if (!receiving) begin
				if (!asic_data) begin // start bit
					receiving <= 1'b1;
					bit_count <= '0;
				end
			end else begin
				bit_count <= bit_count + 1'b1;
				if (last_bit) begin
					receiving <= 1'b0; // next start bit may come right away
					sample_strobe <= 1'b1;
					words_received <= words_received + 1'b1;
				end
			end
		end
	end

	// data path
	always_ff @(posedge sysclk) begin
		if (receiving) begin
			shift <= {shift[sample_bits_c-3:0], asic_data};
			if (last_bit) begin
				sample_word <= {shift, asic_data};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/host_bus_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module host_bus_decoder
	import palimpsest_pkg::*;
#(
	parameter bit ADDRESS_AUTOINCREMENT = 1
) (
	input  wire logic sysclk,
	input  wire logic reset,
	input  wire logic host_strobe,
	input  wire logic host_read,            // 0=write 1=read
	input  wire logic host_register_select, // 0=address 1=data
	input  wire logic [bus_width_c-1:0] host_data_in,
	input  wire data_word_t read_word,      // from readback mux, addressed bank
	output logic [bus_width_c-1:0] host_read_data,
	output logic host_ack,
	output host_address_t address,
	output data_word_t write_data,
	output bank_strobes_t write_strobe,
	output bank_strobes_t read_strobe
);
	logic second_half;                  // next data transaction is the lower half
	logic increment_pending;            // bump address once the strobe cycle is over
	logic [bus_width_c-1:0] held_upper; // upper half of a write in progress
	data_word_t sampled;                // read word captured on the first half
	bank_strobes_t bank_onehot;

	assign bank_onehot = bank_strobes_t'(1) << address.bank;

	// ------------------------------
	// control state
	always_ff @(posedge sysclk) begin
		if (reset) begin
			address <= '0;
			second_half <= 1'b0;
			increment_pending <= 1'b0;
			host_ack <= 1'b0;
			write_strobe <= '0;
			read_strobe <= '0;
		end else begin
			host_ack <= host_strobe; // one cycle after every strobe
			write_strobe <= '0;
			read_strobe <= '0;
			increment_pending <= 1'b0;
			// strobes are out for one cycle with the old address, then step
			if (increment_pending) begin
				address <= host_address_t'(address + 1'b1);
			end
			if (host_strobe) begin
				if (!host_register_select) begin
					if (!host_read) begin
						address <= host_address_t'(host_data_in);
						second_half <= 1'b0; // realign on new address
					end
				end else begin
					second_half <= !second_half;
					if (second_half) begin
						increment_pending <= ADDRESS_AUTOINCREMENT;
						if (!host_read) begin
							write_strobe <= bank_onehot; // word complete
						end
					end else if (host_read) begin
						read_strobe <= bank_onehot; // fifo pops here
					end
				end
			end
		end
	end

	// ------------------------------
	// payload, no reset
	always_ff @(posedge sysclk) begin
		if (host_strobe) begin
			if (!host_register_select) begin
				host_read_data <= address; // address readback
			end else if (!second_half) begin
				held_upper <= host_data_in;
				sampled <= read_word;
				host_read_data <= read_word[data_width_c-1:bus_width_c]; // upper first
			end else begin
				write_data <= {held_upper, host_data_in};
				host_read_data <= sampled[bus_width_c-1:0];
			end
		end
	end

	// host leaves an idle cycle between strobes
	assert property (@(posedge sysclk) disable iff (reset) host_strobe |=> !host_strobe);

endmodule

`default_nettype wire

// ==== hdl/palimpsest_pkg.sv ====
`default_nettype none

package palimpsest_pkg;

	// ------------------------------
	// widths
	localparam int bus_width_c      = 16; // host parallel bus
	localparam int data_width_c     = 32; // two bus transactions
	localparam int bank_sel_width_c = 3;  // top bits of the address word
	localparam int word_sel_width_c = 4;  // 16 words per bank

	// bank numbers
	localparam int bank_general_c = 0; // general settings, ls_i2c
	localparam int bank_status_c  = 1; // read only
	localparam int bank_command_c = 2; // write-to-fire pulses
	localparam int bank_asic_c    = 3; // asic control settings
	localparam int bank_fifo_c    = 5; // sample fifo, read pops

	// command numbers, word offset within bank 2
	localparam int cmd_dreset_c        = 0;
	localparam int cmd_legacy_serial_c = 1;
	localparam int cmd_i2c_c           = 2;
	localparam int cmd_trigger_c       = 3;

	// ------------------------------
	typedef logic [data_width_c-1:0] data_word_t;
	typedef logic [15:0] sample_t; // one asic sample
	typedef logic [(1 << bank_sel_width_c)-1:0] bank_strobes_t; // one bit per bank

	typedef struct packed {
		logic [bank_sel_width_c-1:0] bank;
		logic [bus_width_c-bank_sel_width_c-1:0] offset; // only low 4 bits pick a word
	} host_address_t;

	typedef struct packed {
		logic dreset;
		logic legacy_serial;
		logic i2c;
		logic trigger;
	} command_pulses_t;

	// decoded from bank 3
	typedef struct packed {
		logic [4:0]  i2c_up_addr;           // word 1 [7:3]
		logic        lvdsb_pwr;             // word 1 [2]
		logic        lvdsa_pwr;             // word 1 [1]
		logic        src_sel;               // word 1 [0], keep low for data_a
		logic        tm_reg_reset;          // word 2 [0]
		logic [7:0]  samples_after_trigger; // word 3
		logic [7:0]  lookback_windows;      // word 4
		logic [7:0]  number_of_samples;     // word 5
		logic [15:0] i2c_register_enables;  // word 15
	} asic_settings_t;

endpackage

`default_nettype wire
